/* compile.f */
logic/core_pkg.sv
logic/ctrl_if.sv
logic/control_fsm.sv
logic/reg_file.sv
logic/alu.sv
logic/datapath.sv
logic/core_top.sv
testbench/core_assertions.sv
testbench/core_tb.sv

/* logic/alu.sv */
`timescale 1ns/1ps

module alu (
	input core_pkg::alu_op_t op,
	input core_pkg::word_t a,
	input core_pkg::word_t b,
	output core_pkg::word_t result
);

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb
	begin
		result = '0;
		case (op)
			core_pkg::ALU_ADD: result = a + b;
			core_pkg::ALU_SUB: result = a - b;
			core_pkg::ALU_AND: result = a & b;
			core_pkg::ALU_OR: result = a | b;
			core_pkg::ALU_XOR: result = a ^ b;
			core_pkg::ALU_SLL: result = a << shamt;
			core_pkg::ALU_SRL: result = a >> shamt;
			core_pkg::ALU_SRA: result = $signed(a) >>> shamt;   // sign fill
			default: result = '0;
		endcase
	end

endmodule

/* logic/control_fsm.sv */
`timescale 1ns/1ps

module control_fsm (
	input logic clk,
	input logic rst,
	ctrl_if.seq ctl,
	output logic halted
);

	localparam int CNT_W = $clog2(core_pkg::FETCH_CYCLES) + 1;

	typedef enum logic [3:0] {
		S_START,
		S_FETCH,
		S_DECODE,
		S_LUI,
		S_OP_IMM,
		S_SHIFT_IMM,
		S_OP_REG1,
		S_OP_REG2,
		S_ECALL,
		S_PRINT,
		S_HALT,
		S_WRAP,
		S_INC_PC,
		S_CLEAR
	} state_t;

	state_t state;
	state_t next_state;
	logic [CNT_W-1:0] cnt;                // fetch length, ecall read delay

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;                            // bit 30 picks sub / sra

	assign opcode = ctl.ir[6:0];
	assign funct3 = ctl.ir[14:12];
	assign alt = ctl.ir[30];
	assign halted = (state == S_HALT);

	function automatic core_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic sub_sra);
		core_pkg::alu_op_t op;
		case (f3)
			core_pkg::F3_ADD: op = sub_sra ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
			core_pkg::F3_SLL: op = core_pkg::ALU_SLL;
			core_pkg::F3_XOR: op = core_pkg::ALU_XOR;
			core_pkg::F3_SR: op = sub_sra ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
			core_pkg::F3_OR: op = core_pkg::ALU_OR;
			default: op = core_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	//--------------------------------------------------
	// next state
	//--------------------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			S_START: next_state = S_FETCH;
			S_FETCH:
			begin
				if (cnt == CNT_W'(core_pkg::FETCH_CYCLES - 1))
					next_state = S_DECODE;
			end
			S_DECODE:
			begin
				case (opcode)
					core_pkg::OPC_LUI: next_state = S_LUI;
					core_pkg::OPC_OP_IMM:
					begin
						case (funct3)
							core_pkg::F3_ADD, core_pkg::F3_XOR,
							core_pkg::F3_OR, core_pkg::F3_AND: next_state = S_OP_IMM;
							core_pkg::F3_SLL, core_pkg::F3_SR: next_state = S_SHIFT_IMM;
							default: next_state = S_HALT;     // slti / sltiu
						endcase
					end
					core_pkg::OPC_OP:
					begin
						case (funct3)
							core_pkg::F3_ADD, core_pkg::F3_SLL, core_pkg::F3_XOR,
							core_pkg::F3_SR, core_pkg::F3_OR,
							core_pkg::F3_AND: next_state = S_OP_REG1;
							default: next_state = S_HALT;
						endcase
					end
					core_pkg::OPC_SYSTEM:
						next_state = (ctl.ir[31:7] == '0) ? S_ECALL : S_HALT;
					default: next_state = S_HALT;
				endcase
			end
			S_LUI, S_OP_IMM, S_SHIFT_IMM, S_OP_REG2, S_PRINT: next_state = S_WRAP;
			S_OP_REG1: next_state = S_OP_REG2;
			S_ECALL:
			begin
				// a0 is on port a from the second cycle
				if (cnt != '0)
					next_state = (ctl.rs1_data == core_pkg::SYS_PRINT) ? S_PRINT : S_HALT;
			end
			S_HALT: next_state = S_HALT;             // until reset
			S_WRAP: next_state = S_INC_PC;
			S_INC_PC: next_state = S_CLEAR;
			S_CLEAR: next_state = S_FETCH;
			default: next_state = S_HALT;
		endcase
	end

	//--------------------------------------------------
	// state and strobes
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= S_START;
			cnt <= '0;
			ctl.ir_wren <= 1'b0;
			ctl.reg_wren <= 1'b0;
			ctl.pc_wren <= 1'b0;
			ctl.print_pulse <= 1'b0;
		end
		else
		begin
			state <= next_state;
			case (state)
				S_FETCH:
				begin
					cnt <= cnt + 1'b1;
					ctl.ir_wren <= (cnt == CNT_W'(core_pkg::FETCH_CYCLES - 2));  // last cycle
				end
				S_DECODE: cnt <= '0;
				S_LUI, S_OP_IMM, S_SHIFT_IMM, S_OP_REG2: ctl.reg_wren <= 1'b1;
				S_ECALL: cnt <= cnt + 1'b1;
				S_PRINT: ctl.print_pulse <= 1'b1;
				S_WRAP:
				begin
					ctl.ir_wren <= 1'b0;
					ctl.reg_wren <= 1'b0;
					ctl.pc_wren <= 1'b0;
					ctl.print_pulse <= 1'b0;
				end
				S_INC_PC: ctl.pc_wren <= 1'b1;
				S_CLEAR:
				begin
					ctl.pc_wren <= 1'b0;
					cnt <= '0;
				end
				default: ;
			endcase
		end
	end

	//--------------------------------------------------
	// operand and destination fields
	//--------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
			S_LUI:
			begin
				ctl.rd_addr <= ctl.ir[11:7];
				ctl.imm <= {ctl.ir[31:12], 12'd0};
				ctl.wb_sel <= core_pkg::WB_IMM;
			end
			S_OP_IMM:
			begin
				ctl.rs1_addr <= ctl.ir[19:15];
				ctl.imm <= {{20{ctl.ir[31]}}, ctl.ir[31:20]};
				ctl.alu_b_imm <= 1'b1;
				ctl.alu_op <= alu_sel(funct3, 1'b0);    // addi never subtracts
				ctl.rd_addr <= ctl.ir[11:7];
				ctl.wb_sel <= core_pkg::WB_ALU;
			end
			S_SHIFT_IMM:
			begin
				ctl.rs1_addr <= ctl.ir[19:15];
				ctl.imm <= {27'd0, ctl.ir[24:20]};     // shamt
				ctl.alu_b_imm <= 1'b1;
				ctl.alu_op <= alu_sel(funct3, alt);
				ctl.rd_addr <= ctl.ir[11:7];
				ctl.wb_sel <= core_pkg::WB_ALU;
			end
			S_OP_REG1:
			begin
				ctl.rs1_addr <= ctl.ir[19:15];
				ctl.rs2_addr <= ctl.ir[24:20];
				ctl.alu_b_imm <= 1'b0;
				ctl.alu_op <= alu_sel(funct3, alt);
			end
			S_OP_REG2:
			begin
				ctl.rd_addr <= ctl.ir[11:7];
				ctl.wb_sel <= core_pkg::WB_ALU;
			end
			S_ECALL: ctl.rs1_addr <= core_pkg::REG_A0;
			S_PRINT: ctl.rs1_addr <= core_pkg::REG_A1;
			default: ;
		endcase
	end

endmodule

/* logic/core_pkg.sv */
package core_pkg;

	//--------------------------------------------------
	// widths and types
	//--------------------------------------------------
	localparam int XLEN = 32;
	localparam int REG_COUNT = 32;
	localparam int PC_STEP = 4;
	localparam int FETCH_CYCLES = 2;         // cycles with pc stable before ir load

	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
	typedef logic [2:0] alu_op_t;
	typedef logic wb_sel_t;

	//--------------------------------------------------
	// instruction encodings
	//--------------------------------------------------
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD = 3'b000;  // also sub
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;   // srl / sra by bit 30
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	//--------------------------------------------------
	// datapath selects
	//--------------------------------------------------
	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_SLL = 3'd5;
	localparam alu_op_t ALU_SRL = 3'd6;
	localparam alu_op_t ALU_SRA = 3'd7;

	localparam wb_sel_t WB_ALU = 1'b0;
	localparam wb_sel_t WB_IMM = 1'b1;

	// ecall convention
	localparam reg_addr_t REG_A0 = 5'd10;
	localparam reg_addr_t REG_A1 = 5'd11;
	localparam word_t SYS_PRINT = 32'd1;

endpackage

/* logic/core_top.sv */
`timescale 1ns/1ps

module core_top (
	input logic clk,
	input logic rst,
	input core_pkg::word_t instr,
	output core_pkg::word_t pc,
	output core_pkg::word_t out_value,
	output logic out_update,
	output logic halted
);

	ctrl_if ctl ();

	control_fsm u_ctrl (
		.clk(clk),
		.rst(rst),
		.ctl(ctl.seq),
		.halted(halted)
	);

	datapath u_dp (
		.clk(clk),
		.rst(rst),
		.ctl(ctl.dp),
		.instr(instr),                    // from external imem
		.pc(pc),
		.out_value(out_value),
		.out_update(out_update)
	);

endmodule

/* logic/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;

	core_pkg::reg_addr_t rs1_addr;
	core_pkg::reg_addr_t rs2_addr;
	core_pkg::reg_addr_t rd_addr;
	logic reg_wren;
	core_pkg::wb_sel_t wb_sel;
	logic alu_b_imm;                  // operand b from imm
	core_pkg::alu_op_t alu_op;
	core_pkg::word_t imm;
	logic ir_wren;
	logic pc_wren;
	logic print_pulse;

	// back from the datapath
	core_pkg::word_t ir;
	core_pkg::word_t rs1_data;

	modport seq (
		output rs1_addr, rs2_addr, rd_addr, reg_wren, wb_sel, alu_b_imm,
		output alu_op, imm, ir_wren, pc_wren, print_pulse,
		input ir, rs1_data
	);

	modport dp (
		input rs1_addr, rs2_addr, rd_addr, reg_wren, wb_sel, alu_b_imm,
		input alu_op, imm, ir_wren, pc_wren, print_pulse,
		output ir, rs1_data
	);

endinterface

/* logic/datapath.sv */
`timescale 1ns/1ps

module datapath (
	input logic clk,
	input logic rst,
	ctrl_if.dp ctl,
	input core_pkg::word_t instr,
	output core_pkg::word_t pc,
	output core_pkg::word_t out_value,
	output logic out_update
);

	core_pkg::word_t rs2_data;
	core_pkg::word_t alu_b;
	core_pkg::word_t alu_result;
	core_pkg::word_t wdata;

	//--------------------------------------------------
	// pc and instruction register
	//--------------------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			pc <= '0;
		else if (ctl.pc_wren)
			pc <= pc + core_pkg::word_t'(core_pkg::PC_STEP);
	end

	always_ff @(posedge clk)
	begin
		if (ctl.ir_wren)
			ctl.ir <= instr;
	end

	//--------------------------------------------------
	// execute
	//--------------------------------------------------
	assign alu_b = ctl.alu_b_imm ? ctl.imm : rs2_data;
	assign wdata = (ctl.wb_sel == core_pkg::WB_IMM) ? ctl.imm : alu_result;  // lui

	reg_file u_regs (
		.clk(clk),
		.rst(rst),
		.rs1_addr(ctl.rs1_addr),
		.rs2_addr(ctl.rs2_addr),
		.rd_addr(ctl.rd_addr),
		.wren(ctl.reg_wren),
		.wdata(wdata),
		.rs1_data(ctl.rs1_data),
		.rs2_data(rs2_data)
	);

	alu u_alu (
		.op(ctl.alu_op),
		.a(ctl.rs1_data),
		.b(alu_b),
		.result(alu_result)
	);

	// a1 sits on port a during the print pulse
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			out_update <= 1'b0;
		else
			out_update <= ctl.print_pulse;
	end

	always_ff @(posedge clk)
	begin
		if (ctl.print_pulse)
			out_value <= ctl.rs1_data;
	end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input logic rst,
	input core_pkg::reg_addr_t rs1_addr,
	input core_pkg::reg_addr_t rs2_addr,
	input core_pkg::reg_addr_t rd_addr,
	input logic wren,
	input core_pkg::word_t wdata,
	output core_pkg::word_t rs1_data,
	output core_pkg::word_t rs2_data
);

	core_pkg::word_t regs [core_pkg::REG_COUNT];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 0; i < core_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (wren && rd_addr != '0)       // x0 stays zero
		begin
			regs[rd_addr] <= wdata;
		end
	end

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

endmodule

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module core_tb -o Vcore_tb
./obj_dir/Vcore_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log && ! grep -q "%Error" sim.log
then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* testbench/core_assertions.sv */
`timescale 1ns/1ps

module core_assertions (
	input logic clk,
	input logic rst,
	input core_pkg::word_t pc,
	input logic out_update,
	input logic halted
);

	// halt is sticky until reset
	halt_sticky: assert property (@(posedge clk) disable iff (!rst) halted |=> halted)
		else $error("halted fell without reset");

	print_one_cycle: assert property (@(posedge clk) disable iff (!rst)
		out_update |=> !out_update)
		else $error("out_update high for two cycles");

	pc_aligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
		else $error("pc not word aligned");

	quiet_halt: assert property (@(posedge clk) disable iff (!rst) halted |-> !out_update)
		else $error("out_update while halted");

endmodule

bind core_top core_assertions u_assert (
	.clk(clk),
	.rst(rst),
	.pc(pc),
	.out_update(out_update),
	.halted(halted)
);

/* testbench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

	localparam int MEM_WORDS = 256;

	logic clk;
	logic rst;
	core_pkg::word_t instr;
	core_pkg::word_t pc;
	core_pkg::word_t out_value;
	logic out_update;
	logic halted;

	core_pkg::word_t prog [MEM_WORDS];
	int prog_len;
	core_pkg::word_t model_regs [core_pkg::REG_COUNT];
	logic model_halted;
	core_pkg::word_t expect_halt_pc;
	core_pkg::word_t expect_q [$];
	integer seed;
	int error_count;
	int test_count;
	int fail_tests;
	int cycle_count;
	int cycle_limit;

	core_top uut (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.pc(pc),
		.out_value(out_value),
		.out_update(out_update),
		.halted(halted)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		instr <= prog[pc[9:2]];           // word index

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial
	begin
		wait (cycle_count > cycle_limit);
		$display("timeout: the core did not finish its program within the cycle limit");
		$display("Done: errors found");
		$finish;
	end

	task automatic check_value(input core_pkg::word_t got, input core_pkg::word_t exp,
			input string what);
		if (got !== exp)
		begin
			$display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	function automatic int unsigned pick(input int unsigned n);
		int unsigned r;
		r = $unsigned($random(seed));
		return r % n;
	endfunction

	function automatic core_pkg::reg_addr_t rand_reg();
		return core_pkg::reg_addr_t'(pick(16));  // x0 to x15
	endfunction

	//--------------------------------------------------
	// reference model
	//--------------------------------------------------
	function automatic core_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
			input core_pkg::word_t a, input core_pkg::word_t b);
		logic signed [31:0] sa;
		core_pkg::word_t r;
		sa = a;
		case (f3)
			core_pkg::F3_ADD: r = alt ? a - b : a + b;
			core_pkg::F3_SLL: r = a << b[4:0];
			core_pkg::F3_XOR: r = a ^ b;
			core_pkg::F3_SR:
				if (alt)
					r = sa >>> b[4:0];
				else
					r = a >> b[4:0];
			core_pkg::F3_OR: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic model_write(input core_pkg::reg_addr_t rd, input core_pkg::word_t value);
		if (!model_halted && rd != 5'd0)
			model_regs[rd] = value;
	endtask

	// halt on the word emitted last
	task automatic model_halt();
		if (!model_halted)
		begin
			model_halted = 1'b1;
			expect_halt_pc = core_pkg::word_t'((prog_len - 1) * 4);
		end
	endtask

	//--------------------------------------------------
	// program generation
	//--------------------------------------------------
	task automatic new_program();
		prog_len = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			prog[i] = {25'(i), 7'd0};     // opcode 0 is unsupported
		for (int i = 0; i < core_pkg::REG_COUNT; i++)
			model_regs[i] = '0;
		expect_q.delete();
		model_halted = 1'b0;
		expect_halt_pc = '0;
	endtask

	task automatic emit(input core_pkg::word_t w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic gen_lui_value(input core_pkg::reg_addr_t rd, input logic [19:0] upper);
		emit({upper, rd, core_pkg::OPC_LUI});
		model_write(rd, {upper, 12'd0});
	endtask

	task automatic gen_lui(input core_pkg::reg_addr_t rd);
		gen_lui_value(rd, 20'($random(seed)));
	endtask

	// kind picks addi andi ori xori slli srli srai
	task automatic gen_imm_op(input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
			input int unsigned kind);
		logic [11:0] imm;
		logic [2:0] f3;
		imm = 12'($random(seed));
		case (kind)
			0: f3 = core_pkg::F3_ADD;
			1: f3 = core_pkg::F3_AND;
			2: f3 = core_pkg::F3_OR;
			3: f3 = core_pkg::F3_XOR;
			4: f3 = core_pkg::F3_SLL;
			default: f3 = core_pkg::F3_SR;
		endcase
		if (kind >= 4)
			imm = {1'b0, (kind == 6), 5'd0, imm[4:0]};  // srai sets bit 30
		emit({imm, rs1, f3, rd, core_pkg::OPC_OP_IMM});
		model_write(rd, model_alu(f3, (kind == 6), model_regs[rs1], {{20{imm[11]}}, imm}));
	endtask

	// kind picks add sub and or xor sll srl sra
	task automatic gen_reg_op(input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
			input core_pkg::reg_addr_t rs2, input int unsigned kind);
		logic [2:0] f3;
		logic alt;
		alt = (kind == 1) || (kind == 7);
		case (kind)
			0, 1: f3 = core_pkg::F3_ADD;
			2: f3 = core_pkg::F3_AND;
			3: f3 = core_pkg::F3_OR;
			4: f3 = core_pkg::F3_XOR;
			5: f3 = core_pkg::F3_SLL;
			default: f3 = core_pkg::F3_SR;
		endcase
		emit({1'b0, alt, 5'd0, rs2, rs1, f3, rd, core_pkg::OPC_OP});
		model_write(rd, model_alu(f3, alt, model_regs[rs1], model_regs[rs2]));
	endtask

	task automatic gen_ecall();
		emit({25'd0, core_pkg::OPC_SYSTEM});
		if (!model_halted)
		begin
			if (model_regs[core_pkg::REG_A0] == core_pkg::SYS_PRINT)
				expect_q.push_back(model_regs[core_pkg::REG_A1]);
			else
				model_halt();
		end
	endtask

	// a1 = rs, a0 = 1, ecall
	task automatic gen_print(input core_pkg::reg_addr_t rs);
		emit({12'd0, rs, core_pkg::F3_ADD, core_pkg::REG_A1, core_pkg::OPC_OP_IMM});
		model_write(core_pkg::REG_A1, model_regs[rs]);
		emit({12'd1, 5'd0, core_pkg::F3_ADD, core_pkg::REG_A0, core_pkg::OPC_OP_IMM});
		model_write(core_pkg::REG_A0, 32'd1);
		gen_ecall();
	endtask

	task automatic gen_exit();
		logic [11:0] code;
		code = 12'($random(seed));
		if (code == 12'd1)
			code = 12'd0;
		emit({code, 5'd0, core_pkg::F3_ADD, core_pkg::REG_A0, core_pkg::OPC_OP_IMM});
		model_write(core_pkg::REG_A0, {{20{code[11]}}, code});
		gen_ecall();
	endtask

	task automatic gen_unsupported();
		logic [6:0] opc;
		case (pick(4))
			0: opc = 7'b0000011;          // load
			1: opc = 7'b0100011;          // store
			2: opc = 7'b1100011;          // branch
			default: opc = 7'b0010111;    // auipc
		endcase
		emit({25'($random(seed)), opc});
		model_halt();
	endtask

	//--------------------------------------------------
	// run and check
	//--------------------------------------------------
	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b1;
	endtask

	task automatic run_test(input string name);
		int cycles;
		int printed;
		int errors_before;
		int exp_count;
		core_pkg::word_t halt_pc;
		errors_before = error_count;
		exp_count = expect_q.size();
		printed = 0;
		cycles = 0;
		cycle_limit = cycle_count + prog_len * 12 + 100;
		apply_reset();
		@(negedge clk);
		check_value(pc, 32'd0, "pc after reset");
		check_value(32'(out_update), 32'd0, "out_update after reset");
		check_value(32'(halted), 32'd0, "halted after reset");
		while (!halted)
		begin
			@(negedge clk);
			cycles++;
			if (out_update)
			begin
				printed++;
				if (expect_q.size() > 0)
					check_value(out_value, expect_q.pop_front(), "printed value");
			end
		end
		halt_pc = pc;
		check_value(halt_pc, expect_halt_pc, "pc at halt");
		repeat (20)
		begin
			@(negedge clk);
			check_value(pc, halt_pc, "pc after halt");
			check_value(32'(out_update), 32'd0, "out_update after halt");
			check_value(32'(halted), 32'd1, "halted level");
		end
		check_value(printed, exp_count, "print count");
		test_count++;
		if (error_count != errors_before)
			fail_tests++;
		$display("test %0d %s: %s, %0d prints, %0d cycles", test_count, name,
			(error_count == errors_before) ? "pass" : "fail", printed, cycles);
	endtask

	initial
	begin
		seed = 32'hb8f8;
		rst = 1'b0;
		instr = '0;
		error_count = 0;
		test_count = 0;
		fail_tests = 0;
		cycle_count = 0;
		cycle_limit = 1000;

		new_program();
		gen_exit();
		run_test("reset");

		new_program();
		repeat (12)
		begin
			repeat (3)
			begin
				if (pick(3) == 0)
					gen_lui(rand_reg());
				else
					gen_imm_op(rand_reg(), rand_reg(), pick(7));
			end
			gen_print(rand_reg());
		end
		gen_exit();
		run_test("imm_alu");

		new_program();
		for (int r = 1; r < 16; r++)
		begin
			gen_lui(core_pkg::reg_addr_t'(r));
			gen_imm_op(core_pkg::reg_addr_t'(r), core_pkg::reg_addr_t'(r), 0);
		end
		gen_lui_value(5'd5, 20'hfedcb);   // negative sra operand
		gen_reg_op(5'd6, 5'd5, 5'd7, 7);
		gen_print(5'd6);
		repeat (12)
		begin
			repeat (3)
				gen_reg_op(rand_reg(), rand_reg(), rand_reg(), pick(8));
			gen_print(rand_reg());
		end
		gen_exit();
		run_test("reg_alu");

		new_program();
		gen_lui(5'd1);
		gen_lui(5'd2);
		gen_lui(5'd0);
		gen_imm_op(5'd0, 5'd1, pick(7));
		gen_reg_op(5'd0, 5'd1, 5'd2, 0);
		gen_print(5'd0);
		gen_exit();
		run_test("x0_write");

		new_program();
		repeat (4)
		begin
			gen_imm_op(rand_reg(), rand_reg(), pick(7));
			gen_print(rand_reg());
		end
		gen_exit();
		repeat (2)
			gen_print(rand_reg());        // never reached
		run_test("ecall_halt");

		new_program();
		repeat (3)
		begin
			gen_lui(rand_reg());
			gen_print(rand_reg());
		end
		gen_unsupported();
		repeat (3)
			gen_print(rand_reg());
		gen_exit();
		run_test("bad_opcode");

		$display("%0d tests, %0d failed, %0d errors", test_count, fail_tests, error_count);
		if (error_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
